// ==== Makefile ====
# Verilator flow for the four-stage pipeline
# override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary --timing -Wno-fatal $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/apb_issue_port.sv
source/instr_decode.sv
source/reg_file.sv
source/operand_bypass.sv
source/alu_execute.sv
source/core_top.sv
bench/core_tb.sv

// ==== bench/core_tb.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module core_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int POLL_LIMIT  = 40;
  localparam int READY_LIMIT = 8;

  logic        clk;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] lfsr;
  logic [31:0] model_regs [32];
  int unsigned retired_total;
  instr_t      prog [$];
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;

  core_top core_top_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic instr_t r_type(funct_t fn, logic [4:0] rd, logic [4:0] rs,
                                    logic [4:0] rt);
    return {OP_RTYPE, rs, rt, rd, 5'b0, fn};
  endfunction

  function automatic instr_t i_type(opcode_t op, logic [4:0] rt, logic [4:0] rs,
                                    logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // registers from 0..7 so hazards come often
  function automatic instr_t random_instr();
    funct_t      fns [6];
    logic [2:0]  sel;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
    sel = 3'(draw(3));
    rs  = 5'(draw(3));
    rt  = 5'(draw(3));
    rd  = 5'(draw(3));
    imm = 16'(draw(16));
    case (sel)
      3'd3:    return i_type(OP_ADDIU, rt, rs, imm);
      3'd4:    return i_type(OP_ANDI, rt, rs, imm);
      3'd5:    return i_type(OP_ORI, rt, rs, imm);
      3'd6:    return i_type(OP_LUI, rt, rs, imm);
      3'd7:    return {6'h3f, rs, rt, imm};
      default: return r_type(fns[draw(3) % 6], rd, rs, rt);
    endcase
  endfunction

  // sequential reference, one instruction at a time
  task automatic model_step(input instr_t ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [4:0]  dest;
    logic        wr;
    a    = model_regs[ins[25:21]];
    b    = model_regs[ins[20:16]];
    dest = ins[20:16];
    wr   = 1'b1;
    res  = '0;
    case (ins[31:26])
      OP_RTYPE: begin
        dest = ins[15:11];
        case (ins[5:0])
          FN_ADDU: res = a + b;
          FN_SUBU: res = a - b;
          FN_AND:  res = a & b;
          FN_OR:   res = a | b;
          FN_XOR:  res = a ^ b;
          FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
          default: wr = 1'b0;
        endcase
      end
      OP_ADDIU: res = a + {{16{ins[15]}}, ins[15:0]};
      OP_ANDI:  res = a & {16'b0, ins[15:0]};
      OP_ORI:   res = a | {16'b0, ins[15:0]};
      OP_LUI:   res = {ins[15:0], 16'b0};
      default:  wr = 1'b0;
    endcase
    if (wr && dest != 5'd0)
      model_regs[dest] = res;
    retired_total++;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  // setup cycle, then access until pready
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waited;
    waited = 0;
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready && waited < READY_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!apb_rsp.pready) begin
      $display("Timeout: no pready from the APB port at address %h", addr);
      timed_out = 1'b1;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
    check_value($sformatf("pslverr on write to %h", addr), 32'(err), 32'(exp_err));
  endtask

  task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
    check_value($sformatf("pslverr on read of %h", addr), 32'(err), 32'd0);
  endtask

  task automatic read_expect_err(input logic [7:0] addr);
    logic [31:0] data;
    logic        err;
    apb_transfer(1'b0, addr, '0, data, err);
    check_value($sformatf("pslverr on read of %h", addr), 32'(err), 32'd1);
  endtask

  task automatic check_regs(input string when);
    logic [31:0] data;
    for (int r = 0; r < 32; r++) begin
      read_word(`APB_ADDR_REGS + 8'(4 * r), data);
      check_value($sformatf("%s, register %0d", when, r), data, model_regs[r]);
    end
  endtask

  task automatic check_status();
    logic [31:0] data;
    read_word(`APB_ADDR_STATUS, data);
    check_value("status word", data, {16'b0, 8'(retired_total), 8'b0});
  endtask

  task automatic wait_idle();
    logic [31:0] data;
    int          polls;
    polls = 0;
    read_word(`APB_ADDR_STATUS, data);
    while (data[0] && polls < POLL_LIMIT) begin
      read_word(`APB_ADDR_STATUS, data);
      polls++;
    end
    if (data[0]) begin
      $display("Timeout: core still busy after %0d status reads", polls);
      timed_out = 1'b1;
    end
    // last register write lands four edges after the final issue
    repeat (4) @(posedge clk);
  endtask

  task automatic load_program();
    foreach (prog[i])
      write_expect(`APB_ADDR_BUF + 8'(4 * i), prog[i], 1'b0);
    foreach (prog[i])
      model_step(prog[i]);
  endtask

  task automatic run_program(input string when);
    load_program();
    write_expect(`APB_ADDR_START, 32'(prog.size()), 1'b0);
    wait_idle();
    check_regs(when);
    check_status();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors != 0 || timed_out)
      tests_failed++;
    $display("test %s: %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic test_reset();
    logic [31:0] data;
    read_word(`APB_ADDR_STATUS, data);
    check_value("status after reset", data, 32'h0);
    check_regs("after reset");
    end_test("reset state");
  endtask

  // lui and ori pairs fill registers 1..31
  task automatic test_init();
    logic [31:0] val;
    prog.delete();
    for (int r = 1; r < 32; r++) begin
      val = 32'(r) * 32'h9e37_79b9;
      prog.push_back(i_type(OP_LUI, 5'(r), 5'd0, val[31:16]));
      prog.push_back(i_type(OP_ORI, 5'(r), 5'(r), val[15:0]));
      if (prog.size() == 8 || r == 31) begin
        run_program("init");
        prog.delete();
      end
    end
    end_test("initialization");
  endtask

  task automatic test_forwarding();
    for (int d = 1; d <= 3; d++) begin
      for (int side = 0; side < 2; side++) begin
        prog.delete();
        // r10 changes every run so a stale read shows up
        prog.push_back(i_type(OP_ADDIU, 5'd10, 5'd10, 16'(d * 17 + side + 1)));
        for (int f = 1; f < d; f++)
          prog.push_back(i_type(OP_ORI, 5'(20 + f), 5'd0, 16'(f)));
        if (side == 0)
          prog.push_back(r_type(FN_SUBU, 5'd11, 5'd10, 5'd3));
        else
          prog.push_back(r_type(FN_SUBU, 5'd11, 5'd3, 5'd10));
        run_program($sformatf("distance %0d on %s", d, side ? "rt" : "rs"));
      end
    end
    // memory and write-back both target r12
    prog.delete();
    prog.push_back(i_type(OP_ADDIU, 5'd12, 5'd12, 16'd5));
    prog.push_back(i_type(OP_ADDIU, 5'd12, 5'd12, 16'd7));
    prog.push_back(r_type(FN_ADDU, 5'd13, 5'd3, 5'd12));
    prog.push_back(r_type(FN_SUBU, 5'd14, 5'd12, 5'd3));
    run_program("two writers of r12");
    // rs from memory and rt from write-back in the same cycle
    prog.delete();
    prog.push_back(i_type(OP_ADDIU, 5'd18, 5'd18, 16'd3));
    prog.push_back(i_type(OP_ADDIU, 5'd19, 5'd19, 16'd4));
    prog.push_back(r_type(FN_ADDU, 5'd20, 5'd19, 5'd18));
    run_program("rs from memory and rt from write-back");
    end_test("forwarding");
  endtask

  task automatic test_reg_zero();
    prog.delete();
    prog.push_back(i_type(OP_ADDIU, 5'd0, 5'd1, 16'h0123));
    prog.push_back(r_type(FN_ADDU, 5'd15, 5'd0, 5'd0));
    prog.push_back(r_type(FN_OR, 5'd16, 5'd0, 5'd1));
    // unknown opcode, then unknown funct, both aimed at r2
    prog.push_back({6'h3f, 5'd1, 5'd2, 16'h1234});
    prog.push_back({6'h00, 5'd3, 5'd4, 5'd2, 5'd0, 6'h3f});
    prog.push_back(r_type(FN_ADDU, 5'd17, 5'd2, 5'd0));
    run_program("register zero");
    end_test("register zero");
  endtask

  task automatic test_random();
    int n;
    for (int run = 0; run < 20 && !timed_out; run++) begin
      n = 1 + int'(draw(3));
      prog.delete();
      for (int k = 0; k < n; k++)
        prog.push_back(random_instr());
      run_program($sformatf("random run %0d", run));
    end
    end_test("random runs");
  endtask

  task automatic test_apb_errors();
    logic [31:0] data;
    read_expect_err(8'h28);
    read_expect_err(8'h82);
    write_expect(8'h40, 32'h0, 1'b1);
    write_expect(`APB_ADDR_START, 32'd0, 1'b1);
    write_expect(`APB_ADDR_START, 32'd9, 1'b1);
    check_regs("after rejected accesses");
    check_status();
    prog.delete();
    for (int k = 0; k < 8; k++)
      prog.push_back(random_instr());
    load_program();
    write_expect(`APB_ADDR_START, 32'd8, 1'b0);
    // both rejected while the run is in flight
    write_expect(`APB_ADDR_BUF + 8'd28, i_type(OP_ADDIU, 5'd20, 5'd0, 16'h7777), 1'b1);
    write_expect(`APB_ADDR_START, 32'd3, 1'b1);
    wait_idle();
    read_word(`APB_ADDR_BUF + 8'd28, data);
    check_value("buffer word 7 after a rejected write", data, prog[7]);
    check_regs("after writes during a run");
    check_status();
    end_test("APB errors");
  endtask

  initial begin
    apb_req       = '0;
    arst_n        = 1'b0;
    lfsr          = 32'd56;
    retired_total = 0;
    errors        = 0;
    test_errors   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    timed_out     = 1'b0;
    foreach (model_regs[r])
      model_regs[r] = '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    test_reset();
    if (!timed_out)
      test_init();
    if (!timed_out)
      test_forwarding();
    if (!timed_out)
      test_reg_zero();
    if (!timed_out)
      test_random();
    if (!timed_out)
      test_apb_errors();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== include/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath widths
`define WORD_WIDTH          32
`define REG_ADDR_WIDTH      5
`define REG_COUNT           32

// issue buffer and retire counter
`define ISSUE_DEPTH         8
`define ISSUE_IDX_WIDTH     3
`define RETIRE_COUNT_WIDTH  8

// APB map, byte addresses
`define APB_ADDR_WIDTH      8
`define APB_ADDR_BUF        8'h00
`define APB_ADDR_START      8'h20
`define APB_ADDR_STATUS     8'h24
`define APB_ADDR_REGS       8'h80

`endif

// ==== source/alu_execute.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module alu_execute (
  input  logic                       clk,
  input  logic                       arst_n,
  input  pipe_pkg::pipeline_signal_t ps_execute,
  input  pipe_pkg::forward_info_t    execute_forward,
  output pipe_pkg::pipeline_signal_t ps_memory,
  output pipe_pkg::pipeline_signal_t ps_write_back,
  output logic                       write_enable,
  output logic [`REG_ADDR_WIDTH-1:0] write_addr,
  output logic [`WORD_WIDTH-1:0]     write_data,
  output logic                       retire
);
  import isa_pkg::*;

  unpack_t                ex_unpack;
  logic [`WORD_WIDTH-1:0] op_a;
  logic [`WORD_WIDTH-1:0] rt_val;
  logic [`WORD_WIDTH-1:0] imm_ext;
  logic [`WORD_WIDTH-1:0] op_b;
  logic [`WORD_WIDTH-1:0] result;

  assign ex_unpack = ps_execute.instruction;

  // forwarded value wins over the one captured at decode
  assign op_a   = execute_forward.forward_rs ? execute_forward.rs : ps_execute.rs_data;
  assign rt_val = execute_forward.forward_rt ? execute_forward.rt : ps_execute.rt_data;

  assign imm_ext = ps_execute.control.zero_ext ? {16'b0, ex_unpack.tail.imm}
                                               : {{16{ex_unpack.tail.imm[15]}},
                                                  ex_unpack.tail.imm};
  assign op_b = ps_execute.control.use_imm ? imm_ext : rt_val;

  always_comb begin
    case (ps_execute.control.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_LUI: result = {op_b[15:0], 16'b0};
      default: result = '0;
    endcase
  end

  // memory stage only carries the result along
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ps_memory     <= '0;
      ps_write_back <= '0;
    end else begin
      ps_memory               <= ps_execute;
      ps_memory.rs_data       <= op_a;
      ps_memory.rt_data       <= rt_val;
      ps_memory.dest_reg_data <= result;
      ps_write_back           <= ps_memory;
    end
  end

  assign write_enable = ps_write_back.valid && ps_write_back.control.write_reg;
  assign write_addr   = ps_write_back.dest_reg;
  assign write_data   = ps_write_back.dest_reg_data;
  assign retire       = ps_write_back.valid;

endmodule

// ==== source/apb_issue_port.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module apb_issue_port (
  input  logic                       clk,
  input  logic                       arst_n,
  input  pipe_pkg::apb_req_t         apb_req,
  output pipe_pkg::apb_rsp_t         apb_rsp,
  output logic                       issue_valid,
  output isa_pkg::instr_t            issue_instr,
  input  logic                       retire,
  output logic [`REG_ADDR_WIDTH-1:0] reg_read_addr,
  input  logic [`WORD_WIDTH-1:0]     reg_read_data
);
  import isa_pkg::*;

  instr_t                          buffer [`ISSUE_DEPTH];
  logic                            busy;
  logic [`ISSUE_IDX_WIDTH-1:0]     issue_idx;
  logic [`ISSUE_IDX_WIDTH-1:0]     last_idx;
  logic [`RETIRE_COUNT_WIDTH-1:0]  retired;
  logic [`APB_ADDR_WIDTH-1:0]      buf_offset;
  logic [`APB_ADDR_WIDTH-1:0]      reg_offset;
  logic [`ISSUE_IDX_WIDTH-1:0]     buf_addr;
  logic                            access;
  logic                            aligned;
  logic                            sel_buf;
  logic                            sel_start;
  logic                            sel_status;
  logic                            sel_regs;
  logic                            slv_err;
  logic                            buf_write;
  logic                            start_run;

  // address decode, word accesses only
  assign access     = apb_req.psel && apb_req.penable;
  assign aligned    = apb_req.paddr[1:0] == 2'b00;
  assign buf_offset = apb_req.paddr - `APB_ADDR_BUF;
  assign reg_offset = apb_req.paddr - `APB_ADDR_REGS;
  assign buf_addr   = buf_offset[`ISSUE_IDX_WIDTH+1:2];
  assign sel_buf    = aligned && (buf_offset < (`APB_ADDR_START - `APB_ADDR_BUF));
  assign sel_start  = apb_req.paddr == `APB_ADDR_START;
  assign sel_status = apb_req.paddr == `APB_ADDR_STATUS;
  assign sel_regs   = aligned && (apb_req.paddr >= `APB_ADDR_REGS);
  assign reg_read_addr = reg_offset[`REG_ADDR_WIDTH+1:2];

  // unmapped, write during a run, or START count outside 1..depth
  assign slv_err = !(sel_buf || sel_start || sel_status || sel_regs) ||
                   (apb_req.pwrite && (sel_buf || sel_start) && busy) ||
                   (apb_req.pwrite && sel_start &&
                    (apb_req.pwdata == '0 || apb_req.pwdata > `ISSUE_DEPTH));

  assign buf_write = access && apb_req.pwrite && sel_buf && !slv_err;
  assign start_run = access && apb_req.pwrite && sel_start && !slv_err;

  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && slv_err;
    apb_rsp.prdata  = '0;
    if (access && !apb_req.pwrite) begin
      if (sel_status)
        apb_rsp.prdata = {16'b0, retired, 7'b0, busy};
      else if (sel_regs)
        apb_rsp.prdata = reg_read_data;
      else if (sel_buf)
        apb_rsp.prdata = buffer[buf_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (buf_write)
      buffer[buf_addr] <= apb_req.pwdata;
  end

  // run sequencer, one instruction per cycle until last_idx
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      issue_idx <= '0;
      last_idx  <= '0;
    end else if (start_run) begin
      busy      <= 1'b1;
      issue_idx <= '0;
      last_idx  <= `ISSUE_IDX_WIDTH'(apb_req.pwdata - 1);
    end else if (busy) begin
      issue_idx <= issue_idx + `ISSUE_IDX_WIDTH'(1);
      if (issue_idx == last_idx)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      retired <= '0;
    else if (retire)
      retired <= retired + `RETIRE_COUNT_WIDTH'(1);
  end

  assign issue_valid = busy;
  assign issue_instr = buffer[issue_idx];

endmodule

// ==== source/core_top.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module core_top (
  input  logic               clk,
  input  logic               arst_n,
  input  pipe_pkg::apb_req_t apb_req,
  output pipe_pkg::apb_rsp_t apb_rsp
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic                       issue_valid;
  instr_t                     issue_instr;
  logic                       retire;
  logic [`REG_ADDR_WIDTH-1:0] rf_read_addr [3];
  logic [`WORD_WIDTH-1:0]     rf_read_data [3];
  logic                       write_enable;
  logic [`REG_ADDR_WIDTH-1:0] write_addr;
  logic [`WORD_WIDTH-1:0]     write_data;
  pipeline_signal_t           ps_execute;
  pipeline_signal_t           ps_memory;
  pipeline_signal_t           ps_write_back;
  unpack_t                    decode_unpack;
  unpack_t                    execute_unpack;
  fwd_value_t                 decode_fwd [2];
  fwd_value_t                 execute_fwd [2];
  forward_info_t              decode_forward;
  forward_info_t              execute_forward;

  assign execute_unpack = ps_execute.instruction;

  apb_issue_port apb_issue_port_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .issue_valid   (issue_valid),
    .issue_instr   (issue_instr),
    .retire        (retire),
    .reg_read_addr (rf_read_addr[2]),
    .reg_read_data (rf_read_data[2])
  );

  instr_decode instr_decode_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .issue_valid    (issue_valid),
    .issue_instr    (issue_instr),
    .ps_decode      (),
    .ps_execute     (ps_execute),
    .decode_unpack  (decode_unpack),
    .rf_rs_addr     (rf_read_addr[0]),
    .rf_rt_addr     (rf_read_addr[1]),
    .rf_rs_data     (rf_read_data[0]),
    .rf_rt_data     (rf_read_data[1]),
    .decode_forward (decode_forward)
  );

  reg_file reg_file_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .read_addr    (rf_read_addr),
    .read_data    (rf_read_data),
    .write_enable (write_enable),
    .write_addr   (write_addr),
    .write_data   (write_data)
  );

  // index 0 is rs, index 1 is rt
  for (genvar i = 0; i < 2; i++) begin : g_bypass
    operand_bypass operand_bypass_i (
      .decode_src    ((i == 0) ? decode_unpack.rs : decode_unpack.rt),
      .execute_src   ((i == 0) ? execute_unpack.rs : execute_unpack.rt),
      .ps_memory     (ps_memory),
      .ps_write_back (ps_write_back),
      .decode_fwd    (decode_fwd[i]),
      .execute_fwd   (execute_fwd[i])
    );
  end

  assign decode_forward  = {decode_fwd[0].valid, decode_fwd[1].valid,
                            decode_fwd[0].value, decode_fwd[1].value};
  assign execute_forward = {execute_fwd[0].valid, execute_fwd[1].valid,
                            execute_fwd[0].value, execute_fwd[1].value};

  alu_execute alu_execute_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .ps_execute      (ps_execute),
    .execute_forward (execute_forward),
    .ps_memory       (ps_memory),
    .ps_write_back   (ps_write_back),
    .write_enable    (write_enable),
    .write_addr      (write_addr),
    .write_data      (write_data),
    .retire          (retire)
  );

endmodule

// ==== source/instr_decode.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module instr_decode (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       issue_valid,
  input  isa_pkg::instr_t            issue_instr,
  output pipe_pkg::pipeline_signal_t ps_decode,
  output pipe_pkg::pipeline_signal_t ps_execute,
  output isa_pkg::unpack_t           decode_unpack,
  output logic [`REG_ADDR_WIDTH-1:0] rf_rs_addr,
  output logic [`REG_ADDR_WIDTH-1:0] rf_rt_addr,
  input  logic [`WORD_WIDTH-1:0]     rf_rs_data,
  input  logic [`WORD_WIDTH-1:0]     rf_rt_data,
  input  pipe_pkg::forward_info_t    decode_forward
);
  import isa_pkg::*;
  import pipe_pkg::*;

  unpack_t                    issue_unpack;
  control_t                   issue_ctrl;
  logic [`REG_ADDR_WIDTH-1:0] issue_dest;
  pipeline_signal_t           decode_q;

  assign issue_unpack = issue_instr;

  // control word, rd for R-type and rt for I-type
  always_comb begin
    issue_ctrl = '0;
    issue_dest = issue_unpack.rt;
    case (issue_unpack.opcode)
      OP_RTYPE: begin
        issue_dest           = issue_unpack.tail.r.rd;
        issue_ctrl.write_reg = 1'b1;
        case (issue_unpack.tail.r.funct)
          FN_ADDU: issue_ctrl.alu_op = ALU_ADD;
          FN_SUBU: issue_ctrl.alu_op = ALU_SUB;
          FN_AND:  issue_ctrl.alu_op = ALU_AND;
          FN_OR:   issue_ctrl.alu_op = ALU_OR;
          FN_XOR:  issue_ctrl.alu_op = ALU_XOR;
          FN_SLT:  issue_ctrl.alu_op = ALU_SLT;
          default: issue_ctrl.write_reg = 1'b0;
        endcase
      end
      OP_ADDIU: issue_ctrl = '{1'b1, 1'b1, 1'b0, ALU_ADD};
      OP_ANDI:  issue_ctrl = '{1'b1, 1'b1, 1'b1, ALU_AND};
      OP_ORI:   issue_ctrl = '{1'b1, 1'b1, 1'b1, ALU_OR};
      OP_LUI:   issue_ctrl = '{1'b1, 1'b1, 1'b1, ALU_LUI};
      default:  issue_ctrl = '0;
    endcase
  end

  assign decode_unpack = decode_q.instruction;
  assign rf_rs_addr    = decode_unpack.rs;
  assign rf_rt_addr    = decode_unpack.rt;

  // operands from the register file unless write-back is writing them now
  always_comb begin
    ps_decode         = decode_q;
    ps_decode.rs_data = decode_forward.forward_rs ? decode_forward.rs : rf_rs_data;
    ps_decode.rt_data = decode_forward.forward_rt ? decode_forward.rt : rf_rt_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      decode_q   <= '0;
      ps_execute <= '0;
    end else begin
      decode_q <= '0;
      if (issue_valid) begin
        decode_q.valid       <= 1'b1;
        decode_q.instruction <= issue_instr;
        decode_q.control     <= issue_ctrl;
        decode_q.dest_reg    <= issue_dest;
      end
      ps_execute <= ps_decode;
    end
  end

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] instr_t;

  // primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_ADDIU = 6'h09,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f
  } opcode_t;

  // R-type function codes
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_LUI
  } alu_op_t;

  typedef struct packed {
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_fields_t;

  // low half is either rd/shamt/funct or the immediate
  typedef union packed {
    r_fields_t   r;
    logic [15:0] imm;
  } tail_t;

  typedef struct packed {
    opcode_t    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    tail_t      tail;
  } unpack_t;

endpackage

// ==== source/operand_bypass.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module operand_bypass (
  input  logic [`REG_ADDR_WIDTH-1:0] decode_src,
  input  logic [`REG_ADDR_WIDTH-1:0] execute_src,
  input  pipe_pkg::pipeline_signal_t ps_memory,
  input  pipe_pkg::pipeline_signal_t ps_write_back,
  output pipe_pkg::fwd_value_t       decode_fwd,
  output pipe_pkg::fwd_value_t       execute_fwd
);
  import pipe_pkg::*;

  logic mem_hit_exe;
  logic wb_hit_exe;
  logic wb_hit_dec;

  // a live, writing, nonzero destination that matches src
  function automatic logic hits(pipeline_signal_t ps, logic [`REG_ADDR_WIDTH-1:0] src);
    return ps.valid && ps.control.write_reg && ps.dest_reg != '0 && ps.dest_reg == src;
  endfunction

  assign mem_hit_exe = hits(ps_memory, execute_src);
  assign wb_hit_exe  = hits(ps_write_back, execute_src);
  assign wb_hit_dec  = hits(ps_write_back, decode_src);

  // memory is newer than write-back
  always_comb begin
    execute_fwd = '0;
    if (mem_hit_exe)
      execute_fwd = {1'b1, ps_memory.dest_reg_data};
    else if (wb_hit_exe)
      execute_fwd = {1'b1, ps_write_back.dest_reg_data};
  end

  // decode only sees write-back, the register file has the rest
  always_comb begin
    decode_fwd = '0;
    if (wb_hit_dec)
      decode_fwd = {1'b1, ps_write_back.dest_reg_data};
  end

endmodule

// ==== source/pipe_pkg.sv ====
`include "core_params.svh"

package pipe_pkg;

  typedef struct packed {
    logic             write_reg;
    logic             use_imm;
    logic             zero_ext;
    isa_pkg::alu_op_t alu_op;
  } control_t;

  // one of these per stage
  typedef struct packed {
    logic                       valid;
    isa_pkg::instr_t            instruction;
    control_t                   control;
    logic [`REG_ADDR_WIDTH-1:0] dest_reg;
    logic [`WORD_WIDTH-1:0]     dest_reg_data;
    logic [`WORD_WIDTH-1:0]     rs_data;
    logic [`WORD_WIDTH-1:0]     rt_data;
  } pipeline_signal_t;

  // forwarded value for a single operand
  typedef struct packed {
    logic                   valid;
    logic [`WORD_WIDTH-1:0] value;
  } fwd_value_t;

  typedef struct packed {
    logic                   forward_rs;
    logic                   forward_rt;
    logic [`WORD_WIDTH-1:0] rs;
    logic [`WORD_WIDTH-1:0] rt;
  } forward_info_t;

  typedef struct packed {
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`WORD_WIDTH-1:0]     pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`WORD_WIDTH-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module reg_file (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [`REG_ADDR_WIDTH-1:0] read_addr [3],
  output logic [`WORD_WIDTH-1:0]     read_data [3],
  input  logic                       write_enable,
  input  logic [`REG_ADDR_WIDTH-1:0] write_addr,
  input  logic [`WORD_WIDTH-1:0]     write_data
);

  // register 0 has no storage
  logic [`WORD_WIDTH-1:0] regs [1:`REG_COUNT-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end else if (write_enable && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  // ports 0 and 1 for decode, port 2 for host read-back
  always_comb begin
    for (int i = 0; i < 3; i++)
      read_data[i] = (read_addr[i] == '0) ? '0 : regs[read_addr[i]];
  end

endmodule
